// File: hw/axi_pkg.sv
package axi_pkg;

   // bus geometry
   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = 8;      // one strobe bit per byte lane

   // on-chip sram size, counted in 8-byte words
   localparam int MEM_WORDS = 1024;
   localparam int MEM_AW    = 10;  // word index bits

   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10         // not supported by the sram
   } burst_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } resp_e;

   // read grant owner in the arbiter
   typedef enum logic [1:0] {
      ARB_IDLE = 2'b00,
      ARB_IFU  = 2'b01,
      ARB_MEM  = 2'b10
   } arb_state_e;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        len;    // beats minus one
      logic [2:0]        size;   // always 3 here
      burst_e            burst;
   } ar_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        len;
      logic [2:0]        size;
      burst_e            burst;
   } aw_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      resp_e             resp;
      logic              last;
   } r_beat_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } w_beat_t;

   typedef struct packed {
      resp_e resp;
   } b_resp_t;

endpackage

// File: hw/axi_arbiter.sv
module axi_arbiter (
   input  logic              clk,
   input  logic              rst,

   // fetch port, read only
   input  axi_pkg::ar_req_t  ifu_ar,
   input  logic              ifu_ar_valid,
   output logic              ifu_ar_ready,
   output axi_pkg::r_beat_t  ifu_r,
   output logic              ifu_r_valid,
   input  logic              ifu_r_ready,

   // data port
   input  axi_pkg::ar_req_t  mem_ar,
   input  logic              mem_ar_valid,
   output logic              mem_ar_ready,
   output axi_pkg::r_beat_t  mem_r,
   output logic              mem_r_valid,
   input  logic              mem_r_ready,
   input  axi_pkg::aw_req_t  mem_aw,
   input  logic              mem_aw_valid,
   output logic              mem_aw_ready,
   input  axi_pkg::w_beat_t  mem_w,
   input  logic              mem_w_valid,
   output logic              mem_w_ready,
   output axi_pkg::b_resp_t  mem_b,
   output logic              mem_b_valid,
   input  logic              mem_b_ready,

   // shared bus toward the sram
   output axi_pkg::ar_req_t  bus_ar,
   output logic              bus_ar_valid,
   input  logic              bus_ar_ready,
   input  axi_pkg::r_beat_t  bus_r,
   input  logic              bus_r_valid,
   output logic              bus_r_ready,
   output axi_pkg::aw_req_t  bus_aw,
   output logic              bus_aw_valid,
   input  logic              bus_aw_ready,
   output axi_pkg::w_beat_t  bus_w,
   output logic              bus_w_valid,
   input  logic              bus_w_ready,
   input  axi_pkg::b_resp_t  bus_b,
   input  logic              bus_b_valid,
   output logic              bus_b_ready
);

   axi_pkg::arb_state_e state;      // current read owner
   axi_pkg::arb_state_e state_nxt;
   logic                ar_sent;    // owner's AR already went out
   logic                r_done;     // final beat handed over

   assign r_done = bus_r_valid & bus_r_ready & bus_r.last;

   // grant selection
   always_comb begin
      state_nxt = state;
      case (state)
         axi_pkg::ARB_IDLE: begin
            if (ifu_ar_valid) begin
               state_nxt = axi_pkg::ARB_IFU;    // fetch wins ties
            end else if (mem_ar_valid) begin
               state_nxt = axi_pkg::ARB_MEM;
            end
         end
         axi_pkg::ARB_IFU,
         axi_pkg::ARB_MEM: begin
            if (r_done) begin
               state_nxt = axi_pkg::ARB_IDLE;   // release after last beat
            end
         end
         default: begin
            state_nxt = axi_pkg::ARB_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= axi_pkg::ARB_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // owner may keep valid up after its AR was taken
   always_ff @(posedge clk) begin
      if (rst) begin
         ar_sent <= 1'b0;
      end else if (state == axi_pkg::ARB_IDLE) begin
         ar_sent <= 1'b0;
      end else if (bus_ar_valid && bus_ar_ready) begin
         ar_sent <= 1'b1;
      end
   end

   // read routing, everything zero unless granted
   always_comb begin
      bus_ar       = '0;
      bus_ar_valid = 1'b0;
      bus_r_ready  = 1'b0;
      ifu_ar_ready = 1'b0;
      ifu_r        = '0;
      ifu_r_valid  = 1'b0;
      mem_ar_ready = 1'b0;
      mem_r        = '0;
      mem_r_valid  = 1'b0;
      case (state)
         axi_pkg::ARB_IFU: begin
            bus_ar       = ifu_ar;
            bus_ar_valid = ifu_ar_valid & ~ar_sent;
            ifu_ar_ready = bus_ar_ready & ~ar_sent;
            ifu_r        = bus_r;
            ifu_r_valid  = bus_r_valid;
            bus_r_ready  = ifu_r_ready;  // owner stall holds the sram
         end
         axi_pkg::ARB_MEM: begin
            bus_ar       = mem_ar;
            bus_ar_valid = mem_ar_valid & ~ar_sent;
            mem_ar_ready = bus_ar_ready & ~ar_sent;
            mem_r        = bus_r;
            mem_r_valid  = bus_r_valid;
            bus_r_ready  = mem_r_ready;
         end
         default: begin
         end
      endcase
   end

   // writes only come from the data port
   assign bus_aw       = mem_aw;
   assign bus_aw_valid = mem_aw_valid;
   assign mem_aw_ready = bus_aw_ready;
   assign bus_w        = mem_w;
   assign bus_w_valid  = mem_w_valid;
   assign mem_w_ready  = bus_w_ready;
   assign mem_b        = bus_b;
   assign mem_b_valid  = bus_b_valid;
   assign bus_b_ready  = mem_b_ready;

endmodule

// File: hw/axi_sram.sv
module axi_sram (
   input  logic              clk,
   input  logic              rst,

   // read channels
   input  axi_pkg::ar_req_t  ar,
   input  logic              ar_valid,
   output logic              ar_ready,
   output axi_pkg::r_beat_t  r,
   output logic              r_valid,
   input  logic              r_ready,

   // write channels
   input  axi_pkg::aw_req_t  aw,
   input  logic              aw_valid,
   output logic              aw_ready,
   input  axi_pkg::w_beat_t  w,
   input  logic              w_valid,
   output logic              w_ready,
   output axi_pkg::b_resp_t  b,
   output logic              b_valid,
   input  logic              b_ready
);

   // only fixed and incr are served
   function automatic logic burst_ok(input axi_pkg::burst_e bt);
      burst_ok = (bt == axi_pkg::BURST_FIXED) || (bt == axi_pkg::BURST_INCR);
   endfunction

   logic [axi_pkg::DATA_W-1:0] mem [axi_pkg::MEM_WORDS];

   // read engine
   logic [axi_pkg::ADDR_W-4:0] rd_idx;     // word index of the beat on r
   logic [axi_pkg::ADDR_W-4:0] rd_sel;     // word index of the beat being fetched
   logic [7:0]                 rd_left;    // beats after the current one
   logic                       rd_bad;     // wrap or reserved burst type
   logic                       rd_fixed;
   logic                       ar_hs;
   logic                       r_hs;
   logic                       rd_step;    // advance to the next beat
   logic                       sel_bt_err;
   logic                       sel_err;
   logic                       sel_last;

   assign ar_hs   = ar_valid & ar_ready;
   assign r_hs    = r_valid & r_ready;
   assign rd_step = r_hs & ~r.last;

   // next beat comes from the new request or from the running burst
   always_comb begin
      if (ar_hs) begin
         rd_sel     = ar.addr[axi_pkg::ADDR_W-1:3];
         sel_bt_err = ~burst_ok(ar.burst);
         sel_last   = (ar.len == 8'd0);
      end else begin
         rd_sel     = rd_fixed ? rd_idx : rd_idx + 1'b1;
         sel_bt_err = rd_bad;
         sel_last   = (rd_left == 8'd1);
      end
   end

   assign sel_err = sel_bt_err | (rd_sel >= axi_pkg::MEM_WORDS);  // out of range too

   always_ff @(posedge clk) begin
      if (rst) begin
         ar_ready <= 1'b0;                 // low through reset
         r_valid  <= 1'b0;
         rd_idx   <= '0;
         rd_left  <= '0;
         rd_bad   <= 1'b0;
         rd_fixed <= 1'b0;
      end else if (ar_hs) begin
         ar_ready <= 1'b0;
         r_valid  <= 1'b1;                 // first beat next cycle
         rd_idx   <= rd_sel;
         rd_left  <= ar.len;
         rd_bad   <= ~burst_ok(ar.burst);
         rd_fixed <= (ar.burst == axi_pkg::BURST_FIXED);
      end else if (rd_step) begin
         rd_idx  <= rd_sel;
         rd_left <= rd_left - 8'd1;
      end else if (r_hs) begin
         r_valid  <= 1'b0;                 // last beat taken
         ar_ready <= 1'b1;
      end else if (!r_valid) begin
         ar_ready <= 1'b1;
      end
   end

   // write engine
   logic [axi_pkg::ADDR_W-4:0] wr_idx;
   logic                       wr_bad;     // wrap or reserved burst type
   logic                       wr_fixed;
   logic                       wr_err;     // sticky over the burst
   logic                       aw_hs;
   logic                       w_hs;
   logic                       b_hs;
   logic                       w_beat_err;

   // idle means neither taking data nor holding a response
   assign aw_ready   = ~w_ready & ~b_valid;
   assign aw_hs      = aw_valid & aw_ready;
   assign w_hs       = w_valid & w_ready;
   assign b_hs       = b_valid & b_ready;
   assign w_beat_err = wr_bad | (wr_idx >= axi_pkg::MEM_WORDS);

   always_ff @(posedge clk) begin
      if (rst) begin
         w_ready  <= 1'b0;
         b_valid  <= 1'b0;
         wr_idx   <= '0;
         wr_bad   <= 1'b0;
         wr_fixed <= 1'b0;
         wr_err   <= 1'b0;
      end else if (aw_hs) begin
         w_ready  <= 1'b1;
         wr_idx   <= aw.addr[axi_pkg::ADDR_W-1:3];
         wr_bad   <= ~burst_ok(aw.burst);
         wr_fixed <= (aw.burst == axi_pkg::BURST_FIXED);
         wr_err   <= 1'b0;
      end else if (w_hs) begin
         wr_err <= wr_err | w_beat_err;
         if (!wr_fixed) begin
            wr_idx <= wr_idx + 1'b1;
         end
         if (w.last) begin                 // master's last ends the burst
            w_ready <= 1'b0;
            b_valid <= 1'b1;
         end
      end else if (b_hs) begin
         b_valid <= 1'b0;
      end
   end

   // storage and payload registers
   always_ff @(posedge clk) begin
      if (ar_hs || rd_step) begin
         if (sel_err) begin
            r.data <= '0;
            r.resp <= axi_pkg::RESP_SLVERR;
         end else begin
            r.data <= mem[rd_sel[axi_pkg::MEM_AW-1:0]];
            r.resp <= axi_pkg::RESP_OKAY;
         end
         r.last <= sel_last;               // from the beat count
      end
      if (w_hs && !w_beat_err) begin
         for (int i = 0; i < axi_pkg::STRB_W; i++) begin
            if (w.strb[i]) begin
               mem[wr_idx[axi_pkg::MEM_AW-1:0]][8*i +: 8] <= w.data[8*i +: 8];
            end
         end
      end
      if (w_hs && w.last) begin
         if (wr_err || w_beat_err) begin
            b.resp <= axi_pkg::RESP_SLVERR;
         end else begin
            b.resp <= axi_pkg::RESP_OKAY;
         end
      end
   end

endmodule

// File: hw/axi_mem_sys.sv
module axi_mem_sys (
   input  logic              clk,
   input  logic              rst,

   // instruction fetch read port
   input  axi_pkg::ar_req_t  ifu_ar,
   input  logic              ifu_ar_valid,
   output logic              ifu_ar_ready,
   output axi_pkg::r_beat_t  ifu_r,
   output logic              ifu_r_valid,
   input  logic              ifu_r_ready,

   // data memory port
   input  axi_pkg::ar_req_t  mem_ar,
   input  logic              mem_ar_valid,
   output logic              mem_ar_ready,
   output axi_pkg::r_beat_t  mem_r,
   output logic              mem_r_valid,
   input  logic              mem_r_ready,
   input  axi_pkg::aw_req_t  mem_aw,
   input  logic              mem_aw_valid,
   output logic              mem_aw_ready,
   input  axi_pkg::w_beat_t  mem_w,
   input  logic              mem_w_valid,
   output logic              mem_w_ready,
   output axi_pkg::b_resp_t  mem_b,
   output logic              mem_b_valid,
   input  logic              mem_b_ready
);

   // arbiter to sram
   axi_pkg::ar_req_t bus_ar;
   logic             bus_ar_valid;
   logic             bus_ar_ready;
   axi_pkg::r_beat_t bus_r;
   logic             bus_r_valid;
   logic             bus_r_ready;
   axi_pkg::aw_req_t bus_aw;
   logic             bus_aw_valid;
   logic             bus_aw_ready;
   axi_pkg::w_beat_t bus_w;
   logic             bus_w_valid;
   logic             bus_w_ready;
   axi_pkg::b_resp_t bus_b;
   logic             bus_b_valid;
   logic             bus_b_ready;

   axi_arbiter i_arbiter (.*);  // port names match the top and the bus wires

   axi_sram i_sram (
      .clk      (clk),
      .rst      (rst),
      .ar       (bus_ar),
      .ar_valid (bus_ar_valid),
      .ar_ready (bus_ar_ready),
      .r        (bus_r),
      .r_valid  (bus_r_valid),
      .r_ready  (bus_r_ready),
      .aw       (bus_aw),
      .aw_valid (bus_aw_valid),
      .aw_ready (bus_aw_ready),
      .w        (bus_w),
      .w_valid  (bus_w_valid),
      .w_ready  (bus_w_ready),
      .b        (bus_b),
      .b_valid  (bus_b_valid),
      .b_ready  (bus_b_ready)
   );

endmodule

// File: testbench/axi_arbiter_chk.sv
module axi_arbiter_chk (
   input logic                clk,
   input logic                rst,
   input axi_pkg::arb_state_e state,
   input logic                ifu_r_valid,
   input logic                mem_r_valid,
   input logic                bus_ar_valid,
   input logic                bus_ar_ready
);

   // r beats go to the owner only
   r_owner_only: assert property (@(posedge clk) disable iff (rst)
      !(ifu_r_valid && mem_r_valid))
      else $error("ifu_r_valid and mem_r_valid high in the same cycle");

   ar_held: assert property (@(posedge clk) disable iff (rst)
      bus_ar_valid && !bus_ar_ready |=> bus_ar_valid)
      else $error("bus_ar_valid dropped before bus_ar_ready");

   ar_not_idle: assert property (@(posedge clk) disable iff (rst)
      state == axi_pkg::ARB_IDLE |-> !bus_ar_valid)
      else $error("bus_ar_valid high while the arbiter is idle");

   // owner may still hold valid after its ar
   one_ar_per_grant: assert property (@(posedge clk) disable iff (rst)
      (bus_ar_valid && bus_ar_ready) |=> !bus_ar_valid)
      else $error("second ar forwarded within one grant");

   idle_after_reset: assert property (@(posedge clk) rst |=> state == axi_pkg::ARB_IDLE)
      else $error("arbiter not idle after reset");

endmodule

bind axi_arbiter axi_arbiter_chk i_chk (
   .clk          (clk),
   .rst          (rst),
   .state        (state),
   .ifu_r_valid  (ifu_r_valid),
   .mem_r_valid  (mem_r_valid),
   .bus_ar_valid (bus_ar_valid),
   .bus_ar_ready (bus_ar_ready)
);

// File: testbench/tb_axi_mem_sys.sv
module tb_axi_mem_sys;

   // beats per test in run order
   localparam int TOTAL_BEATS = 1024 + 8 + 7 + 8 + 160 + 22 + 92;

   logic clk = 1'b0;
   logic rst;
   axi_pkg::ar_req_t ifu_ar, mem_ar;
   axi_pkg::r_beat_t ifu_r, mem_r;
   axi_pkg::aw_req_t mem_aw;
   axi_pkg::w_beat_t mem_w;
   axi_pkg::b_resp_t mem_b;
   logic ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;
   logic mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
   logic mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
   logic mem_b_valid, mem_b_ready;

   integer           seed;
   logic [31:0]      rnd;
   logic [31:0]      rnd_rdy;
   logic             stall_r;                  // random r_ready when set
   logic             stall_b;
   logic [63:0]      shadow [axi_pkg::MEM_WORDS];  // expected sram words
   axi_pkg::ar_req_t pend [2];                 // open read per port with 0 as fetch
   logic             pend_v [2];
   int               beat_n [2];
   int               first_cyc [2];            // cycle of beat 0
   axi_pkg::resp_e   exp_b;
   logic             exp_b_v;
   int               cyc = 0;
   int               errors = 0;
   int               checks = 0;
   int               err_mark = 0;

   axi_mem_sys i_dut (.*);

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   always @(negedge clk) begin
      rnd_rdy = $random(seed);
      ifu_r_ready = stall_r ? rnd_rdy[0] : 1'b1;
      mem_r_ready = stall_r ? rnd_rdy[1] : 1'b1;
      mem_b_ready = stall_b ? rnd_rdy[2] : 1'b1;
   end

   // pattern over the whole word index
   function automatic logic [63:0] fill_word(input logic [31:0] idx);
      fill_word = {idx ^ 32'h5a3c_0f96, ~idx};
   endfunction

   function automatic axi_pkg::r_beat_t expected_beat(input logic [31:0] addr,
         input axi_pkg::burst_e bt, input int beat, input logic [63:0] sh [axi_pkg::MEM_WORDS]);
      logic [31:0] idx;
      idx = {3'b000, addr[31:3]};
      if (bt == axi_pkg::BURST_INCR) begin
         idx = idx + beat;
      end
      expected_beat = '0;                      // last is set by the caller
      if ((bt != axi_pkg::BURST_FIXED && bt != axi_pkg::BURST_INCR) ||
          idx >= axi_pkg::MEM_WORDS) begin
         expected_beat.resp = axi_pkg::RESP_SLVERR;   // zero data on error
      end else begin
         expected_beat.data = sh[idx];
         expected_beat.resp = axi_pkg::RESP_OKAY;
      end
   endfunction

   task automatic check_r_beat(input int p, input axi_pkg::r_beat_t got);
      axi_pkg::r_beat_t exp;
      string nm;
      nm = (p == 0) ? "ifu_r" : "mem_r";
      if (!pend_v[p]) begin
         $display("%s: extra beat with no read outstanding", nm);
         errors++;
      end else begin
         exp = expected_beat(pend[p].addr, pend[p].burst, beat_n[p], shadow);
         exp.last = (beat_n[p] == int'(pend[p].len));
         checks++;
         if (got.data !== exp.data) begin
            $display("CHECK FAILED %s.data beat %0d exp %h got %h", nm, beat_n[p],
                     exp.data, got.data);
            errors++;
         end
         if (got.resp !== exp.resp) begin
            $display("CHECK FAILED %s.resp beat %0d exp %h got %h", nm, beat_n[p],
                     exp.resp, got.resp);
            errors++;
         end
         if (exp.last && !got.last) begin
            $display("%s: last missing on final beat %0d", nm, beat_n[p]);
            errors++;
         end
         if (got.last && !exp.last) begin
            $display("%s: last came early on beat %0d of %0d", nm, beat_n[p], pend[p].len);
            errors++;
         end
         if (beat_n[p] == 0) begin
            first_cyc[p] = cyc;
         end
         beat_n[p]++;
         if (exp.last || got.last) begin
            pend_v[p] = 1'b0;                  // burst retired
         end
      end
   endtask

   // compare on every transfer
   always @(posedge clk) begin
      if (ifu_r_valid && ifu_r_ready) begin
         check_r_beat(0, ifu_r);
      end
      if (mem_r_valid && mem_r_ready) begin
         check_r_beat(1, mem_r);
      end
      if (mem_b_valid && mem_b_ready) begin
         if (!exp_b_v) begin
            $display("mem_b: response arrived with no write outstanding");
            errors++;
         end else begin
            checks++;
            if (mem_b.resp !== exp_b) begin
               $display("CHECK FAILED mem_b.resp exp %h got %h", exp_b, mem_b.resp);
               errors++;
            end
            exp_b_v = 1'b0;
         end
      end
   end

   task automatic read_burst(input int p, input logic [31:0] addr,
                             input axi_pkg::burst_e bt, input int len);
      axi_pkg::ar_req_t req;
      req = '{addr: addr, len: 8'(len), size: 3'd3, burst: bt};
      @(negedge clk);
      pend[p] = req;
      beat_n[p] = 0;
      pend_v[p] = 1'b1;
      if (p == 0) begin
         ifu_ar = req;
         ifu_ar_valid = 1'b1;
         do @(posedge clk); while (!ifu_ar_ready);
         @(negedge clk);
         ifu_ar_valid = 1'b0;
      end else begin
         mem_ar = req;
         mem_ar_valid = 1'b1;
         do @(posedge clk); while (!mem_ar_ready);
         @(negedge clk);
         mem_ar_valid = 1'b0;
      end
      while (pend_v[p]) @(posedge clk);       // compare process retires it
   endtask

   // strb_seq holds one strobe byte per beat and repeats every 8 beats
   task automatic write_burst(input logic [31:0] addr, input axi_pkg::burst_e bt,
                              input int len, input logic [63:0] strb_seq, input bit fill);
      logic [31:0] idx;
      logic        bad;
      bad = 1'b0;
      @(negedge clk);
      mem_aw = '{addr: addr, len: 8'(len), size: 3'd3, burst: bt};
      mem_aw_valid = 1'b1;
      do @(posedge clk); while (!mem_aw_ready);
      @(negedge clk);
      mem_aw_valid = 1'b0;
      for (int i = 0; i <= len; i++) begin
         idx = {3'b000, addr[31:3]} + ((bt == axi_pkg::BURST_INCR) ? i : 0);
         mem_w.data = fill ? fill_word(idx) : {$random(seed), $random(seed)};
         mem_w.strb = strb_seq[8*(i%8) +: 8];
         mem_w.last = (i == len);
         mem_w_valid = 1'b1;
         do @(posedge clk); while (!mem_w_ready);
         if ((bt != axi_pkg::BURST_FIXED && bt != axi_pkg::BURST_INCR) ||
             idx >= axi_pkg::MEM_WORDS) begin
            bad = 1'b1;                        // beat dropped
         end else begin
            for (int k = 0; k < 8; k++) begin
               if (mem_w.strb[k]) begin
                  shadow[idx][8*k +: 8] = mem_w.data[8*k +: 8];
               end
            end
         end
         @(negedge clk);
      end
      mem_w_valid = 1'b0;
      exp_b = bad ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
      exp_b_v = 1'b1;
      while (exp_b_v) @(posedge clk);
   endtask

   task automatic report_test(input string name);
      $display("test %-12s %0d checks so far, %0d new errors", name, checks, errors - err_mark);
      err_mark = errors;
   endtask

   initial begin
      rst = 1'b1;
      seed = 32'h09207f35;
      stall_r = 1'b0;
      stall_b = 1'b0;
      ifu_ar = '0;
      ifu_ar_valid = 1'b0;
      ifu_r_ready = 1'b1;
      mem_ar = '0;
      mem_ar_valid = 1'b0;
      mem_r_ready = 1'b1;
      mem_aw = '0;
      mem_aw_valid = 1'b0;
      mem_w = '0;
      mem_w_valid = 1'b0;
      mem_b_ready = 1'b1;
      pend_v[0] = 1'b0;
      pend_v[1] = 1'b0;
      exp_b_v = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int q = 0; q < 4; q++) begin       // whole sram in four 256-beat bursts
         write_burst(q * 32'h800, axi_pkg::BURST_INCR, 255, '1, 1'b1);
      end
      report_test("fill");
      write_burst(32'h100, axi_pkg::BURST_INCR, 3, '1, 1'b0);
      read_burst(1, 32'h100, axi_pkg::BURST_INCR, 3);
      report_test("incr");
      write_burst(32'h200, axi_pkg::BURST_FIXED, 2, 64'h00F0_3C03, 1'b0);  // overlapping lanes
      read_burst(0, 32'h200, axi_pkg::BURST_FIXED, 0);
      read_burst(1, 32'h1F8, axi_pkg::BURST_INCR, 2);
      report_test("strobes");
      fork
         read_burst(0, 32'h040, axi_pkg::BURST_INCR, 3);
         read_burst(1, 32'h080, axi_pkg::BURST_INCR, 3);
      join
      if (!(first_cyc[0] < first_cyc[1])) begin
         $display("fetch burst did not start first, fetch cycle %0d data cycle %0d",
                  first_cyc[0], first_cyc[1]);
         errors++;
      end
      report_test("contention");
      stall_r = 1'b1;
      for (int n = 0; n < 20; n++) begin
         rnd = $random(seed);
         read_burst(n % 2, {19'd0, rnd[12:3], 3'd0},
                    rnd[13] ? axi_pkg::BURST_INCR : axi_pkg::BURST_FIXED, int'(rnd[16:14]));
      end
      stall_r = 1'b0;
      report_test("backpressure");
      read_burst(1, 32'h2000, axi_pkg::BURST_INCR, 1);    // past the end
      read_burst(0, 32'h1FF0, axi_pkg::BURST_INCR, 3);    // runs off the end
      write_burst(32'h2000, axi_pkg::BURST_INCR, 1, '1, 1'b0);
      read_burst(1, 32'h100, axi_pkg::BURST_WRAP, 3);
      write_burst(32'h100, axi_pkg::BURST_WRAP, 1, '1, 1'b0);
      read_burst(1, 32'h000, axi_pkg::BURST_INCR, 3);     // low words if index wrapped
      read_burst(0, 32'h100, axi_pkg::BURST_INCR, 3);
      report_test("errors");
      stall_b = 1'b1;
      for (int n = 0; n < 5; n++) begin
         rnd = $random(seed);
         write_burst(32'h1000 + {23'd0, rnd[5:0], 3'd0},
                     rnd[8] ? axi_pkg::BURST_INCR : axi_pkg::BURST_FIXED,
                     int'(rnd[7:6]), {$random(seed), $random(seed)}, 1'b0);
      end
      stall_b = 1'b0;
      for (int k = 0; k < 9; k++) begin       // region plus overhang
         read_burst(1, 32'h1000 + k * 64, axi_pkg::BURST_INCR, 7);
      end
      report_test("b2b_writes");
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // watchdog with a per-beat budget
   initial begin
      repeat (TOTAL_BEATS * 20 + 200) @(posedge clk);
      $display("timeout after %0d cycles, a handshake never completed", cyc);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: src.f
hw/axi_pkg.sv
hw/axi_arbiter.sv
hw/axi_sram.sv
hw/axi_mem_sys.sv
testbench/axi_arbiter_chk.sv
testbench/tb_axi_mem_sys.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_axi_mem_sys
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), log to $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
